/* Makefile */
.PHONY: sim clean

# Build, run into sim.log, and pass only if the log holds the pass line
sim:
	verilator --binary --assert -f tsc_cpu.f --top-module tsc_cpu_tb -o tsc_cpu_sim
	./obj_dir/tsc_cpu_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  tsc_pkg::word_t   i_a,
    input  tsc_pkg::word_t   i_b,
    input  tsc_pkg::alu_op_e i_op,
    output tsc_pkg::word_t   o_result,
    output logic             o_cond
);
    import tsc_pkg::*;

    always_comb begin
        o_result = '0;
        o_cond   = 1'b0;
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_ORR: o_result = i_a | i_b;
            ALU_NOT: o_result = ~i_a;
            ALU_TCP: o_result = ~i_a + 16'd1;
            ALU_SHL: o_result = {i_a[WORD_W-2:0], 1'b0};
            // Sign bit is kept on a right shift
            ALU_SHR: o_result = {i_a[WORD_W-1], i_a[WORD_W-1:1]};
            ALU_LHI: o_result = {i_b[7:0], 8'h00};
            // Branch tests compare rs with rt or with zero
            ALU_NE:  o_cond = (i_a != i_b);
            ALU_EQ:  o_cond = (i_a == i_b);
            ALU_GZ:  o_cond = ($signed(i_a) > 0);
            ALU_LZ:  o_cond = i_a[WORD_W-1];
            default: ;
        endcase
    end

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit #(
    parameter int MEM_ADDR_W = 16
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           i_inst_valid,
    input  tsc_pkg::word_t i_inst,
    input  tsc_pkg::word_t i_inst_pc_next,
    output logic           o_inst_take,
    output logic           o_redirect,
    output tsc_pkg::word_t o_redirect_target,
    output logic           o_data_req,
    output logic           o_data_write,
    output tsc_pkg::word_t o_data_addr,
    output tsc_pkg::word_t o_data_wdata,
    input  logic           i_data_done,
    input  tsc_pkg::word_t i_rdata,
    output tsc_pkg::word_t o_num_inst,
    output tsc_pkg::word_t o_output_port,
    output logic           o_output_strobe,
    output logic           o_is_halted
);
    import tsc_pkg::*;

    typedef enum logic [1:0] {RUN, MEM, HALT} state_e;

    state_e    state;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    reg_addr_t load_dest;
    word_t     imm_ext;
    word_t     rs_data;
    word_t     rt_data;
    word_t     alu_result;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      branch;
    logic      jump;
    logic      wwd;
    logic      hlt;
    logic      cond;
    logic      retire_now;
    logic      load_write;

    instr_decoder u_decoder (
        .i_inst      (i_inst),
        .o_rs        (rs),
        .o_rt        (rt),
        .o_rd        (),
        .o_imm_ext   (imm_ext),
        .o_alu_op    (alu_op),
        .o_use_imm   (use_imm),
        .o_reg_write (reg_write),
        .o_dest      (dest),
        .o_mem_read  (mem_read),
        .o_mem_write (mem_write),
        .o_branch    (branch),
        .o_jump      (jump),
        .o_wwd       (wwd),
        .o_hlt       (hlt)
    );

    register_file u_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_read_addr1 (rs),
        .i_read_addr2 (rt),
        .o_read_data1 (rs_data),
        .o_read_data2 (rt_data),
        .i_write      ((retire_now && reg_write) || load_write),
        .i_write_addr (load_write ? load_dest : dest),
        .i_write_data (load_write ? i_rdata : alu_result)
    );

    alu u_alu (
        .i_a      (rs_data),
        .i_b      (use_imm ? imm_ext : rt_data),
        .i_op     (alu_op),
        .o_result (alu_result),
        .o_cond   (cond)
    );

    ////////////////////////////////////////////////////////////
    // Take, retire and redirect
    ////////////////////////////////////////////////////////////

    assign o_inst_take = (state == RUN) && i_inst_valid;
    assign retire_now  = o_inst_take && !(mem_read || mem_write);
    assign load_write  = (state == MEM) && i_data_done && !o_data_write;
    assign o_is_halted = (state == HALT);

    assign o_redirect        = retire_now && ((branch && cond) || jump);
    assign o_redirect_target = jump ? {i_inst_pc_next[15:12], i_inst[11:0]}
                                    : i_inst_pc_next + imm_ext;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state           <= RUN;
            o_data_req      <= 1'b0;
            o_data_write    <= 1'b0;
            o_num_inst      <= '0;
            o_output_port   <= '0;
            o_output_strobe <= 1'b0;
        end else begin
            o_output_strobe <= retire_now && wwd;
            if (retire_now && wwd) begin
                o_output_port <= rs_data;
            end
            case (state)
                RUN: begin
                    if (o_inst_take && (mem_read || mem_write)) begin
                        state        <= MEM;
                        o_data_req   <= 1'b1;
                        o_data_write <= mem_write;
                    end else if (o_inst_take) begin
                        o_num_inst <= o_num_inst + 16'd1;
                        if (hlt) begin
                            state <= HALT;
                        end
                    end
                end
                MEM: begin
                    // Load or store retires on the data done pulse
                    if (i_data_done) begin
                        state      <= RUN;
                        o_data_req <= 1'b0;
                        o_num_inst <= o_num_inst + 16'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Access payload is captured when the instruction is taken
    always_ff @(posedge clk) begin
        if (o_inst_take) begin
            o_data_addr  <= word_t'(alu_result[MEM_ADDR_W-1:0]);
            o_data_wdata <= rt_data;
            load_dest    <= dest;
        end
    end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int MEM_ADDR_W = 16
) (
    input  logic           clk,
    input  logic           reset_n,
    output logic           o_fetch_req,
    output tsc_pkg::word_t o_fetch_addr,
    input  logic           i_fetch_done,
    input  tsc_pkg::word_t i_rdata,
    output logic           o_inst_valid,
    output tsc_pkg::word_t o_inst,
    output tsc_pkg::word_t o_inst_pc_next,
    input  logic           i_inst_take,
    input  logic           i_redirect,
    input  tsc_pkg::word_t i_redirect_target
);
    import tsc_pkg::*;

    word_t pc;
    word_t pc_next;
    logic  pending;
    logic  discard;
    logic  accept;

    assign pc_next = pc + 16'd1;

    // Keep an open request alive, start a new one once the buffer frees up
    assign o_fetch_req  = pending || !o_inst_valid || i_inst_take;
    assign o_fetch_addr = word_t'(pc[MEM_ADDR_W-1:0]);

    // A fetch that was outdated by a redirect is dropped on completion
    assign accept = i_fetch_done && !discard && !i_redirect;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc           <= RESET_PC;
            o_inst_valid <= 1'b0;
            pending      <= 1'b0;
            discard      <= 1'b0;
        end else begin
            pending <= o_fetch_req && !i_fetch_done;
            if (i_redirect) begin
                pc           <= i_redirect_target;
                o_inst_valid <= 1'b0;
                discard      <= o_fetch_req && !i_fetch_done;
            end else begin
                if (i_fetch_done) begin
                    discard <= 1'b0;
                end
                if (accept) begin
                    pc           <= pc_next;
                    o_inst_valid <= 1'b1;
                end else if (i_inst_take) begin
                    o_inst_valid <= 1'b0;
                end
            end
        end
    end

    // Instruction buffer payload
    always_ff @(posedge clk) begin
        if (accept) begin
            o_inst         <= i_rdata;
            o_inst_pc_next <= pc_next;
        end
    end

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  tsc_pkg::word_t     i_inst,
    output tsc_pkg::reg_addr_t o_rs,
    output tsc_pkg::reg_addr_t o_rt,
    output tsc_pkg::reg_addr_t o_rd,
    output tsc_pkg::word_t     o_imm_ext,
    output tsc_pkg::alu_op_e   o_alu_op,
    output logic               o_use_imm,
    output logic               o_reg_write,
    output tsc_pkg::reg_addr_t o_dest,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output logic               o_branch,
    output logic               o_jump,
    output logic               o_wwd,
    output logic               o_hlt
);
    import tsc_pkg::*;

    opcode_e opcode;
    func_e   func;

    assign opcode = opcode_e'(i_inst[15:12]);
    assign func   = func_e'(i_inst[5:0]);
    assign o_rs   = i_inst[11:10];
    assign o_rt   = i_inst[9:8];
    assign o_rd   = i_inst[7:6];

    always_comb begin
        o_imm_ext   = {{8{i_inst[7]}}, i_inst[7:0]};
        o_alu_op    = ALU_ADD;
        o_use_imm   = 1'b0;
        o_reg_write = 1'b0;
        o_dest      = i_inst[9:8];
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_branch    = 1'b0;
        o_jump      = 1'b0;
        o_wwd       = 1'b0;
        o_hlt       = 1'b0;
        case (opcode)
            OP_BNE: begin
                o_branch = 1'b1;
                o_alu_op = ALU_NE;
            end
            OP_BEQ: begin
                o_branch = 1'b1;
                o_alu_op = ALU_EQ;
            end
            OP_BGZ: begin
                o_branch = 1'b1;
                o_alu_op = ALU_GZ;
            end
            OP_BLZ: begin
                o_branch = 1'b1;
                o_alu_op = ALU_LZ;
            end
            OP_ADI: begin
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            // ORI and LHI take the immediate unsigned
            OP_ORI: begin
                o_imm_ext   = {8'h00, i_inst[7:0]};
                o_alu_op    = ALU_ORR;
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_LHI: begin
                o_imm_ext   = {8'h00, i_inst[7:0]};
                o_alu_op    = ALU_LHI;
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_LWD: begin
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
                o_mem_read  = 1'b1;
            end
            OP_SWD: begin
                o_use_imm   = 1'b1;
                o_mem_write = 1'b1;
            end
            OP_JMP: o_jump = 1'b1;
            OP_RTYPE: begin
                o_dest = i_inst[7:6];
                case (func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                        o_alu_op    = alu_op_e'(i_inst[3:0]);
                        o_reg_write = 1'b1;
                    end
                    FN_WWD: o_wwd = 1'b1;
                    FN_HLT: o_hlt = 1'b1;
                    default: ;
                endcase
            end
            // Unused opcodes fall through as no-ops
            default: ;
        endcase
    end

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           i_fetch_req,
    input  tsc_pkg::word_t i_fetch_addr,
    output logic           o_fetch_done,
    input  logic           i_data_req,
    input  logic           i_data_write,
    input  tsc_pkg::word_t i_data_addr,
    input  tsc_pkg::word_t i_data_wdata,
    output logic           o_data_done,
    output tsc_pkg::word_t o_rdata,
    output logic           o_mem_read,
    output logic           o_mem_write,
    output tsc_pkg::word_t o_mem_address,
    output tsc_pkg::word_t o_mem_wdata,
    input  tsc_pkg::word_t i_mem_rdata,
    input  logic           i_mem_ready
);
    import tsc_pkg::*;

    typedef enum logic [1:0] {IDLE, FETCH, DATA} owner_e;

    owner_e owner;

    // Data side wins when both are waiting
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            owner       <= IDLE;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end else begin
            case (owner)
                IDLE: begin
                    if (i_data_req) begin
                        owner       <= DATA;
                        o_mem_read  <= !i_data_write;
                        o_mem_write <= i_data_write;
                    end else if (i_fetch_req) begin
                        owner      <= FETCH;
                        o_mem_read <= 1'b1;
                    end
                end
                default: begin
                    if (i_mem_ready) begin
                        owner       <= IDLE;
                        o_mem_read  <= 1'b0;
                        o_mem_write <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Address and data only move while no transfer is open
    always_ff @(posedge clk) begin
        if (owner == IDLE) begin
            o_mem_address <= i_data_req ? i_data_addr : i_fetch_addr;
            o_mem_wdata   <= i_data_wdata;
        end
    end

    assign o_fetch_done = (owner == FETCH) && i_mem_ready;
    assign o_data_done  = (owner == DATA) && i_mem_ready;
    assign o_rdata      = i_mem_rdata;

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  tsc_pkg::reg_addr_t i_read_addr1,
    input  tsc_pkg::reg_addr_t i_read_addr2,
    output tsc_pkg::word_t     o_read_data1,
    output tsc_pkg::word_t     o_read_data2,
    input  logic               i_write,
    input  tsc_pkg::reg_addr_t i_write_addr,
    input  tsc_pkg::word_t     i_write_data
);
    import tsc_pkg::*;

    word_t regs [4];

    // Asynchronous read ports
    assign o_read_data1 = regs[i_read_addr1];
    assign o_read_data2 = regs[i_read_addr2];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            regs <= '{default: '0};
        end else if (i_write) begin
            regs[i_write_addr] <= i_write_data;
        end
    end

endmodule

/* hw/tsc_cpu.sv */
`timescale 1ns/1ps

module tsc_cpu #(
    parameter int MEM_ADDR_W = 16
) (
    input  logic           clk,
    input  logic           reset_n,
    output logic           o_mem_read,
    output logic           o_mem_write,
    output tsc_pkg::word_t o_mem_address,
    output tsc_pkg::word_t o_mem_wdata,
    input  tsc_pkg::word_t i_mem_rdata,
    input  logic           i_mem_ready,
    output tsc_pkg::word_t o_num_inst,
    output tsc_pkg::word_t o_output_port,
    output logic           o_output_strobe,
    output logic           o_is_halted
);
    import tsc_pkg::*;

    logic  fetch_req;
    word_t fetch_addr;
    logic  fetch_done;
    logic  data_req;
    logic  data_write;
    word_t data_addr;
    word_t data_wdata;
    logic  data_done;
    word_t rdata;
    logic  inst_valid;
    word_t inst;
    word_t inst_pc_next;
    logic  inst_take;
    logic  redirect;
    word_t redirect_target;

    fetch_unit #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) u_fetch (
        .clk               (clk),
        .reset_n           (reset_n),
        .o_fetch_req       (fetch_req),
        .o_fetch_addr      (fetch_addr),
        .i_fetch_done      (fetch_done),
        .i_rdata           (rdata),
        .o_inst_valid      (inst_valid),
        .o_inst            (inst),
        .o_inst_pc_next    (inst_pc_next),
        .i_inst_take       (inst_take),
        .i_redirect        (redirect),
        .i_redirect_target (redirect_target)
    );

    exec_unit #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) u_exec (
        .clk               (clk),
        .reset_n           (reset_n),
        .i_inst_valid      (inst_valid),
        .i_inst            (inst),
        .i_inst_pc_next    (inst_pc_next),
        .o_inst_take       (inst_take),
        .o_redirect        (redirect),
        .o_redirect_target (redirect_target),
        .o_data_req        (data_req),
        .o_data_write      (data_write),
        .o_data_addr       (data_addr),
        .o_data_wdata      (data_wdata),
        .i_data_done       (data_done),
        .i_rdata           (rdata),
        .o_num_inst        (o_num_inst),
        .o_output_port     (o_output_port),
        .o_output_strobe   (o_output_strobe),
        .o_is_halted       (o_is_halted)
    );

    // Single memory port shared by both requesters
    mem_arbiter u_arbiter (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_fetch_req   (fetch_req),
        .i_fetch_addr  (fetch_addr),
        .o_fetch_done  (fetch_done),
        .i_data_req    (data_req),
        .i_data_write  (data_write),
        .i_data_addr   (data_addr),
        .i_data_wdata  (data_wdata),
        .o_data_done   (data_done),
        .o_rdata       (rdata),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_mem_address (o_mem_address),
        .o_mem_wdata   (o_mem_wdata),
        .i_mem_rdata   (i_mem_rdata),
        .i_mem_ready   (i_mem_ready)
    );

endmodule

/* hw/tsc_pkg.sv */
package tsc_pkg;

    // Datapath width and reset vector
    localparam logic [15:0] WORD_W = 16'd16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [1:0]        reg_addr_t;

    localparam word_t RESET_PC = 16'h0000;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    // Top nibble of the instruction word
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    // Low six bits of an R-type word
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    // First eight line up with FN_ADD..FN_SHR
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_ORR = 4'd3,
        ALU_NOT = 4'd4,
        ALU_TCP = 4'd5,
        ALU_SHL = 4'd6,
        ALU_SHR = 4'd7,
        ALU_LHI = 4'd8,
        ALU_NE  = 4'd9,
        ALU_EQ  = 4'd10,
        ALU_GZ  = 4'd11,
        ALU_LZ  = 4'd12
    } alu_op_e;

endpackage

/* tsc_cpu.f */
hw/tsc_pkg.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/alu.sv
hw/exec_unit.sv
hw/tsc_cpu.sv
verification/tsc_cpu_tb.sv

/* verification/tsc_cpu_tb.sv */
`timescale 1ns/1ps

module tsc_cpu_tb;
    import tsc_pkg::*;

    localparam int FIRST_READ_TIMEOUT = 10;
    localparam int HALT_TIMEOUT       = 20000;
    localparam int QUIET_TIMEOUT      = 500;
    localparam int QUIET_NEEDED       = 20;

    logic  clk         = 1'b0;
    logic  reset_n     = 1'b0;
    word_t i_mem_rdata = '0;
    logic  i_mem_ready = 1'b0;
    logic  o_mem_read;
    logic  o_mem_write;
    word_t o_mem_address;
    word_t o_mem_wdata;
    word_t o_num_inst;
    word_t o_output_port;
    logic  o_output_strobe;
    logic  o_is_halted;
    logic  mem_req;

    // Vectors image and the memory behind the port
    logic [15:0] vectors [0:511];
    word_t       mem [0:255];

    logic [31:0] rng_state    = 32'hb112;
    int          wait_left    = 0;
    int          strobe_count = 0;
    int          req_count    = 0;
    int          ready_count  = 0;
    int          halt_reqs    = 0;
    logic        halt_seen    = 1'b0;
    logic        last_req     = 1'b0;
    logic        last_ready   = 1'b0;
    word_t       last_addr    = '0;
    word_t       last_wdata   = '0;

    tsc_cpu #(
        .MEM_ADDR_W (16)
    ) tsc_cpu_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .o_mem_read      (o_mem_read),
        .o_mem_write     (o_mem_write),
        .o_mem_address   (o_mem_address),
        .o_mem_wdata     (o_mem_wdata),
        .i_mem_rdata     (i_mem_rdata),
        .i_mem_ready     (i_mem_ready),
        .o_num_inst      (o_num_inst),
        .o_output_port   (o_output_port),
        .o_output_strobe (o_output_strobe),
        .o_is_halted     (o_is_halted)
    );

    always #10 clk = ~clk;

    assign mem_req = o_mem_read || o_mem_write;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got === expected) else
            report_error($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected));
    endtask

    task automatic check_idle_outputs();
        check_value("o_mem_read", 16'(o_mem_read), 16'h0000);
        check_value("o_mem_write", 16'(o_mem_write), 16'h0000);
        check_value("o_output_strobe", 16'(o_output_strobe), 16'h0000);
        check_value("o_is_halted", 16'(o_is_halted), 16'h0000);
        check_value("o_num_inst", o_num_inst, 16'h0000);
        check_value("o_output_port", o_output_port, 16'h0000);
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model with a random latency of 1 to 4 cycles
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        i_mem_ready <= 1'b0;
        if (!reset_n) begin
            wait_left = 0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= vectors[i];
            end
        end else if (mem_req && !i_mem_ready) begin
            assert (o_mem_address < 16'd256) else
                report_error("memory access outside the 256-word model");
            if (wait_left == 0) begin
                rng_state = xorshift32(rng_state);
                wait_left = int'(rng_state[1:0]) + 1;
            end
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                i_mem_ready <= 1'b1;
                if (o_mem_write) begin
                    mem[o_mem_address[7:0]] <= o_mem_wdata;
                end else begin
                    i_mem_rdata <= mem[o_mem_address[7:0]];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Port protocol and output monitors
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset_n) begin
            assert (!(o_mem_read && o_mem_write)) else
                report_error("read and write strobes are high together");
            assert (!i_mem_ready || mem_req) else
                report_error("ready pulse without an open request");
            if (last_ready) begin
                assert (!mem_req) else
                    report_error("request still high in the cycle after ready");
            end
            // Address and data must hold within one transfer
            if (last_req && mem_req) begin
                check_value("o_mem_address", o_mem_address, last_addr);
                check_value("o_mem_wdata", o_mem_wdata, last_wdata);
            end
            if (mem_req && !last_req) begin
                req_count++;
                if (halt_seen) begin
                    halt_reqs++;
                end
            end
            if (i_mem_ready) begin
                ready_count++;
            end
            last_req   <= mem_req;
            last_ready <= i_mem_ready;
            last_addr  <= o_mem_address;
            last_wdata <= o_mem_wdata;
        end
    end

    always @(posedge clk) begin
        if (reset_n && o_output_strobe) begin
            assert (strobe_count < int'(vectors[257])) else
                report_error("more output strobes than WWD instructions in the program");
            check_value("o_output_port", o_output_port, vectors[258 + strobe_count]);
            strobe_count++;
        end
        if (reset_n && halt_seen) begin
            assert (o_is_halted === 1'b1) else
                report_error("o_is_halted dropped after the core halted");
        end
        if (reset_n && o_is_halted === 1'b1) begin
            halt_seen <= 1'b1;
        end
    end

    initial begin
        int cycles;
        int quiet;
        // Words outside the file get an address-dependent fill
        for (int i = 0; i < 512; i++) begin
            vectors[i] = 16'hA000 ^ 16'(i);
        end
        $readmemh("verification/tsc_cpu_vectors.mem", vectors);

        @(posedge clk);
        repeat (9) begin
            @(posedge clk);
            check_idle_outputs();
        end
        reset_n <= 1'b1;
        @(posedge clk);
        check_idle_outputs();

        cycles = 0;
        while (o_mem_read !== 1'b1 && cycles < FIRST_READ_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (o_mem_read === 1'b1) else
            report_error("timeout waiting for the first instruction read");
        assert (cycles == 1) else
            report_error("first memory read did not start one cycle after reset release");
        check_value("o_mem_address", o_mem_address, RESET_PC);

        cycles = 0;
        while (o_is_halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (o_is_halted === 1'b1) else
            report_error("timeout waiting for o_is_halted");

        // Let the prefetch settle until the port stays idle
        cycles = 0;
        quiet  = 0;
        while (quiet < QUIET_NEEDED && cycles < QUIET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (mem_req || i_mem_ready) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        assert (quiet >= QUIET_NEEDED) else
            report_error("memory port did not go idle after halt");

        check_value("o_num_inst", o_num_inst, vectors[256]);
        check_value("o_output_strobe count", 16'(strobe_count), vectors[257]);
        assert (halt_reqs < 10) else
            report_error($sformatf("%0d memory requests after halt, ten or more", halt_reqs));
        assert (req_count == ready_count) else
            report_error("number of memory requests and ready pulses differ");
        for (int i = 0; i < 16; i++) begin
            check_value($sformatf("mem[0x%h]", 8'(240 + i)), mem[240 + i], vectors[496 + i]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* verification/tsc_cpu_vectors.mem */
// Hex words, up to eight per line, address set by the @ lines
// 0-255 memory image, 256 retired count, 257 WWD count, 258+ WWD values
// 496-511 expected final words at memory addresses 0xF0-0xFF
@000
// Constants, ALU chain and shifts
6112 5534 42FD F6C0 FC1C F6C1 FEC2 4048
FCC3 FC1C FCC4 FCC7 FC1C FCC5 FCC6 FC1C
// Base 0xF0, stores and loads
6000 50F0 8302 8105 7208 FBC0 FC1C 7102
// BEQ untaken, BNE taken, TCP, BGZ and BLZ both ways
830F 8200 1602 0602 4F01 4F02 FC1C F885
2801 3801 4F04 2402 4F08 F01D 3401 4F10
// Backward BGZ loop, then JMP over HLT words
6200 4A03 FFC0 4AFF 28FD FC1C 9032 F01D
F01D F01D 8309 FCC7 61A5 810C FC1C F41C
// Unused opcode as no-op, then HLT
A123 F01D

// Data region, the load at 0xF8 reads 0x0A5C
@0F0
C0F0 C0F1 C0F2 C0F3 C0F4 C0F5 C0F6 C0F7
0A5C C0F9 C0FA C0FB C0FC C0FD C0FE C0FF

// Retired count, WWD count, WWD values in order
@100
0038 0009
1231 127D F6C1 127E 1CDA 1CDA E750 F3A8
A500

// Final words at 0xF0-0xFF
@1F0
0A5C C0F1 127E C0F3 C0F4 1234 C0F6 C0F7
0A5C E750 C0FA C0FB A500 C0FD C0FE 1CDA
